// File: logic/bldc_settings.svh
/*
 * BLDC driver settings: widths, duty limits, dead time, hall sampling
 * and startup ramp timing shared by all blocks
 */
`ifndef BLDC_SETTINGS_SVH
`define BLDC_SETTINGS_SVH

// ============================================================
// PWM
// ============================================================

// Width of the duty command and of the PWM counter, period is 1024 clocks
`define BLDC_DUTY_WIDTH 10

// Roughly 5 percent of full scale, the motor only runs above this
`define BLDC_MIN_DUTY 51

// Clocks with both gates off at every bridge handover
`define BLDC_DEAD_TIME 8

// ============================================================
// Hall sensor supervision
// ============================================================

// The hall code is evaluated once every this many clocks
`define BLDC_HALL_SAMPLE_DIV 16

// Consecutive qualifying samples needed to latch or clear a condition
`define BLDC_HALL_STEADY_COUNT 8

// ============================================================
// Startup ramp
// ============================================================

`define BLDC_RAMP_TICK_CYCLES 64
`define BLDC_RAMP_STEPS 16
// Duty added on every ramp tick
`define BLDC_RAMP_INCREMENT 4

`endif

// File: logic/bldc_pkg.sv
/*
 * BLDC driver package: shared vector types, the motor state encoding,
 * the hall status and drive command structs and the commutation table
 */
`include "bldc_settings.svh"

package bldc_pkg;

    // Duty cycle command, also the width of the PWM counter
    typedef logic [`BLDC_DUTY_WIDTH-1:0] duty_t;

    // Raw or synchronised hall code, one bit per sensor
    typedef logic [2:0] hall_t;

    // One bit per phase with a, b and c on bits 0, 1 and 2
    typedef logic [2:0] phase_mask_t;

    typedef enum logic [2:0] {
        st_stop,
        st_startup,
        st_run,
        st_poll_hall,
        st_err
    } motor_state_e;

    // Hall monitor view handed to the state machine and the commutator
    typedef struct packed {
        hall_t code;
        logic  hw_fault;
        logic  disconnected;
        // Single clock pulse when either latch sets
        logic  new_fault;
    } hall_status_t;

    // Drive request for the three half bridges
    typedef struct packed {
        duty_t       duty;
        phase_mask_t pwm_mask;
        phase_mask_t low_mask;
        phase_mask_t float_mask;
    } drive_cmd_t;

    // Six-step table, duty is left at zero for the caller to fill in.
    // Reverse direction swaps the switching and the low phase.
    function automatic drive_cmd_t commute(hall_t code, logic direction);
        drive_cmd_t  cmd;
        phase_mask_t hi;
        phase_mask_t lo;
        cmd = '0;
        case (code)
            3'd1: begin
                hi = 3'b001;
                lo = 3'b010;
            end
            3'd3: begin
                hi = 3'b001;
                lo = 3'b100;
            end
            3'd2: begin
                hi = 3'b010;
                lo = 3'b100;
            end
            3'd6: begin
                hi = 3'b010;
                lo = 3'b001;
            end
            3'd4: begin
                hi = 3'b100;
                lo = 3'b001;
            end
            3'd5: begin
                hi = 3'b100;
                lo = 3'b010;
            end
            // Codes 0 and 7 are not valid rotor positions
            default: begin
                hi = 3'b000;
                lo = 3'b000;
            end
        endcase
        cmd.pwm_mask   = direction ? lo : hi;
        cmd.low_mask   = direction ? hi : lo;
        cmd.float_mask = ~(hi | lo);
        return cmd;
    endfunction

endpackage

// File: logic/hall_monitor.sv
/*
 * Hall monitor: synchronises the hall lines and latches the all-low
 * hardware fault, the all-high disconnect and the later reconnection
 */
`timescale 1ns/1ps
`include "bldc_settings.svh"

module hall_monitor import bldc_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  hall_t        hall,
    output hall_status_t status,
    output logic         connected
);

    localparam int div_w = $clog2(`BLDC_HALL_SAMPLE_DIV);
    localparam int cnt_w = $clog2(`BLDC_HALL_STEADY_COUNT);
    localparam logic [div_w-1:0] div_last = div_w'(`BLDC_HALL_SAMPLE_DIV - 1);
    // A latch acts on the sample that arrives while its counter sits here
    localparam logic [cnt_w-1:0] steady_last = cnt_w'(`BLDC_HALL_STEADY_COUNT - 1);

    hall_t            hall_meta;
    hall_t            hall_sync;
    logic [div_w-1:0] div_cnt;
    logic             sample_en;
    logic             code_low;
    logic             code_high;
    logic [cnt_w-1:0] low_cnt;
    logic [cnt_w-1:0] high_cnt;
    logic [cnt_w-1:0] valid_cnt;
    logic             hw_fault;
    logic             disconnected;
    logic             new_fault;
    logic             set_hw;
    logic             set_disc;
    logic             clr_disc;

    // Two flop synchroniser, the sensor lines are asynchronous to clk
    always_ff @(posedge clk) begin
        if (rst) begin
            hall_meta <= '0;
            hall_sync <= '0;
        end else begin
            hall_meta <= hall;
            hall_sync <= hall_meta;
        end
    end

    // ============================================================
    // Reduced rate sampling
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst || sample_en) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sample_en = (div_cnt == div_last);
    assign code_low  = (hall_sync == 3'b000);
    assign code_high = (hall_sync == 3'b111);

    // Steady counters saturate one short of the limit, the next matching
    // sample then fires the latch
    always_ff @(posedge clk) begin
        if (rst) begin
            low_cnt   <= '0;
            high_cnt  <= '0;
            valid_cnt <= '0;
        end else if (sample_en) begin
            if (!code_low) begin
                low_cnt <= '0;
            end else if (low_cnt != steady_last) begin
                low_cnt <= low_cnt + 1'b1;
            end
            if (!code_high) begin
                high_cnt <= '0;
            end else if (high_cnt != steady_last) begin
                high_cnt <= high_cnt + 1'b1;
            end
            // Valid codes only count toward reconnection once disconnected
            if (!disconnected || code_low || code_high) begin
                valid_cnt <= '0;
            end else if (valid_cnt != steady_last) begin
                valid_cnt <= valid_cnt + 1'b1;
            end
        end
    end

    // ============================================================
    // Fault and disconnect latches
    // ============================================================

    // An all-low code seen while unplugged is not a wiring fault
    assign set_hw   = sample_en && code_low && (low_cnt == steady_last)
                      && !hw_fault && !disconnected;
    assign set_disc = sample_en && code_high && (high_cnt == steady_last) && !disconnected;
    assign clr_disc = sample_en && !code_low && !code_high
                      && (valid_cnt == steady_last) && disconnected;

    always_ff @(posedge clk) begin
        if (rst) begin
            hw_fault     <= 1'b0;
            disconnected <= 1'b0;
            new_fault    <= 1'b0;
        end else begin
            new_fault <= set_hw || set_disc;
            if (set_disc) begin
                // Unplugging the sensor is the only way out of a hardware fault
                disconnected <= 1'b1;
                hw_fault     <= 1'b0;
            end else begin
                if (clr_disc) begin
                    disconnected <= 1'b0;
                end
                if (set_hw) begin
                    hw_fault <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        status.code         = hall_sync;
        status.hw_fault     = hw_fault;
        status.disconnected = disconnected;
        status.new_fault    = new_fault;
    end

    assign connected = !disconnected;

    // The two latches exclude each other
    assert property (@(posedge clk) disable iff (rst) !(hw_fault && disconnected));

endmodule

// File: logic/ramp_timer.sv
/*
 * Startup ramp timer: ticks once per ramp period and flags the end of
 * the fixed length startup
 */
`timescale 1ns/1ps
`include "bldc_settings.svh"

module ramp_timer (
    input  logic clk,
    input  logic rst,
    input  logic ramp_run,
    output logic ramp_tick,
    output logic ramp_done
);

    localparam int tick_w = $clog2(`BLDC_RAMP_TICK_CYCLES);
    localparam int step_w = $clog2(`BLDC_RAMP_STEPS + 1);
    localparam logic [tick_w-1:0] tick_last = tick_w'(`BLDC_RAMP_TICK_CYCLES - 1);
    localparam logic [step_w-1:0] step_end  = step_w'(`BLDC_RAMP_STEPS);

    logic [tick_w-1:0] tick_cnt;
    logic [step_w-1:0] step_cnt;

    // Both counters sit at zero whenever the motor is not starting up
    always_ff @(posedge clk) begin
        if (rst || !ramp_run) begin
            tick_cnt  <= '0;
            step_cnt  <= '0;
            ramp_tick <= 1'b0;
        end else begin
            ramp_tick <= (tick_cnt == tick_last);
            if (tick_cnt == tick_last) begin
                tick_cnt <= '0;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            // Step count saturates at the ramp length
            if (ramp_tick && !ramp_done) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    assign ramp_done = (step_cnt == step_end);

endmodule

// File: logic/motor_fsm.sv
/*
 * Motor controller: stop, startup ramp, run, hall polling and error
 * states, picking the duty cycle applied to the bridges
 */
`timescale 1ns/1ps
`include "bldc_settings.svh"

module motor_fsm import bldc_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         en,
    input  duty_t        duty,
    input  hall_status_t status,
    input  logic         ramp_tick,
    input  logic         ramp_done,
    output logic         ramp_run,
    output duty_t        applied_duty,
    output logic         drive_on,
    output logic         fault
);

    localparam duty_t min_duty = duty_t'(`BLDC_MIN_DUTY);
    localparam duty_t ramp_inc = duty_t'(`BLDC_RAMP_INCREMENT);

    motor_state_e state;
    logic         above_min;

    assign above_min = (duty > min_duty);

    // ============================================================
    // State register and duty selection
    // ============================================================

    always_ff @(posedge clk) begin
        if (rst || !en) begin
            state        <= st_stop;
            applied_duty <= '0;
        end else if (status.new_fault) begin
            // A fresh latch overrides whatever the motor was doing
            state        <= status.hw_fault ? st_err : st_poll_hall;
            applied_duty <= '0;
        end else begin
            case (state)
                st_stop: begin
                    // Latches set while disabled are picked up here
                    if (status.hw_fault) begin
                        state <= st_err;
                    end else if (status.disconnected) begin
                        state <= st_poll_hall;
                    end else if (above_min) begin
                        state        <= st_startup;
                        applied_duty <= min_duty;
                    end
                end
                st_startup: begin
                    if (!above_min) begin
                        state        <= st_stop;
                        applied_duty <= '0;
                    end else if (ramp_done) begin
                        state        <= st_run;
                        applied_duty <= duty;
                    end else if (ramp_tick) begin
                        applied_duty <= applied_duty + ramp_inc;
                    end
                end
                st_run: begin
                    if (!above_min) begin
                        state        <= st_stop;
                        applied_duty <= '0;
                    end else begin
                        applied_duty <= duty;
                    end
                end
                st_err: begin
                    // Held until the sensor is unplugged and the fault clears
                    if (!status.hw_fault) begin
                        state <= st_poll_hall;
                    end
                end
                st_poll_hall: begin
                    if (!status.disconnected) begin
                        state <= st_stop;
                    end
                end
                default: begin
                    state <= st_stop;
                end
            endcase
        end
    end

    // ============================================================
    // Outputs decoded from the state
    // ============================================================

    assign ramp_run = (state == st_startup);
    assign drive_on = (state == st_startup) || (state == st_run);
    assign fault    = (state == st_err);

    // Whenever the bridges are driven the applied duty sits at or above the minimum
    assert property (@(posedge clk) disable iff (rst)
        drive_on |-> (applied_duty >= min_duty));

endmodule

// File: logic/commutator.sv
/*
 * Commutator: maps hall code, direction and applied duty onto the
 * registered per-phase drive command
 */
`timescale 1ns/1ps

module commutator import bldc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  hall_t      code,
    input  logic       direction,
    input  logic       drive_on,
    input  duty_t      applied_duty,
    output drive_cmd_t cmd
);

    // All bridges floating with zero duty
    localparam drive_cmd_t cmd_idle = '{
        duty:       '0,
        pwm_mask:   '0,
        low_mask:   '0,
        float_mask: '1
    };

    drive_cmd_t cmd_next;

    always_comb begin
        cmd_next      = commute(code, direction);
        cmd_next.duty = applied_duty;
        if (!drive_on) begin
            cmd_next = cmd_idle;
        end
    end

    // Registered so a commutation step lands on a clock edge for all phases
    always_ff @(posedge clk) begin
        if (rst) begin
            cmd <= cmd_idle;
        end else begin
            cmd <= cmd_next;
        end
    end

endmodule

// File: logic/phase_pwm.sv
/*
 * Half-bridge PWM generator: edge aligned PWM with dead time at each
 * handover and after any change of role or duty
 */
`timescale 1ns/1ps
`include "bldc_settings.svh"

module phase_pwm import bldc_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  duty_t duty,
    input  logic  pwm_sel,
    input  logic  low_sel,
    input  logic  float_sel,
    output logic  gate_h,
    output logic  gate_l
);

    localparam int dead_w = $clog2(`BLDC_DEAD_TIME + 1);
    localparam int ext_w  = `BLDC_DUTY_WIDTH + 1;
    localparam duty_t dead_duty = duty_t'(`BLDC_DEAD_TIME);
    localparam logic [dead_w-1:0] dead_load = dead_w'(`BLDC_DEAD_TIME - 1);

    duty_t             cnt;
    duty_t             prev_duty;
    logic [2:0]        prev_sel;
    logic [dead_w-1:0] dead_cnt;
    logic              changed;
    logic              hold;
    logic [ext_w-1:0]  l_start;
    logic              h_win;
    logic              l_win;

    // Free running period counter, the common reset keeps phases aligned
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // ============================================================
    // Change detection and forced dead time
    // ============================================================

    assign changed = (duty != prev_duty) || ({pwm_sel, low_sel, float_sel} != prev_sel);
    assign hold    = changed || (dead_cnt != '0);

    // The change cycle itself counts as the first off cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_duty <= '0;
            prev_sel  <= 3'b001;
            dead_cnt  <= '0;
        end else begin
            prev_duty <= duty;
            prev_sel  <= {pwm_sel, low_sel, float_sel};
            if (changed) begin
                dead_cnt <= dead_load;
            end else if (dead_cnt != '0) begin
                dead_cnt <= dead_cnt - 1'b1;
            end
        end
    end

    // ============================================================
    // Gate windows
    // ============================================================

    // High side starts after the wrap gap, low side after the falling gap.
    // The low window start is one bit wider so a large duty never wraps.
    assign l_start = {1'b0, duty} + ext_w'(`BLDC_DEAD_TIME);
    assign h_win   = (cnt >= dead_duty) && (cnt < duty);
    assign l_win   = ({1'b0, cnt} >= l_start);

    always_ff @(posedge clk) begin
        if (rst || hold || float_sel) begin
            gate_h <= 1'b0;
            gate_l <= 1'b0;
        end else if (low_sel) begin
            gate_h <= 1'b0;
            gate_l <= 1'b1;
        end else if (pwm_sel) begin
            gate_h <= h_win;
            gate_l <= l_win;
        end else begin
            gate_h <= 1'b0;
            gate_l <= 1'b0;
        end
    end

    // Shoot-through guard
    assert property (@(posedge clk) disable iff (rst) !(gate_h && gate_l));

    // Each side going off leaves the other side off for the dead time
    assert property (@(posedge clk) disable iff (rst)
        $fell(gate_h) |-> !gate_l [*`BLDC_DEAD_TIME]);
    assert property (@(posedge clk) disable iff (rst)
        $fell(gate_l) |-> !gate_h [*`BLDC_DEAD_TIME]);

endmodule

// File: logic/bldc_driver.sv
/*
 * BLDC driver top: hall supervision, motor state machine, startup ramp,
 * six-step commutation and three dead-time PWM half bridges
 */
`timescale 1ns/1ps

module bldc_driver import bldc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        en,
    input  hall_t       hall,
    input  duty_t       duty,
    input  logic        direction,
    output phase_mask_t phase_h,
    output phase_mask_t phase_l,
    output logic        connected,
    output logic        fault
);

    hall_status_t hall_status;
    logic         ramp_run;
    logic         ramp_tick;
    logic         ramp_done;
    logic         drive_on;
    duty_t        applied_duty;
    drive_cmd_t   drive_cmd;

    hall_monitor u_hall_monitor (
        .clk       (clk),
        .rst       (rst),
        .hall      (hall),
        .status    (hall_status),
        .connected (connected)
    );

    ramp_timer u_ramp_timer (
        .clk       (clk),
        .rst       (rst),
        .ramp_run  (ramp_run),
        .ramp_tick (ramp_tick),
        .ramp_done (ramp_done)
    );

    motor_fsm u_motor_fsm (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .duty         (duty),
        .status       (hall_status),
        .ramp_tick    (ramp_tick),
        .ramp_done    (ramp_done),
        .ramp_run     (ramp_run),
        .applied_duty (applied_duty),
        .drive_on     (drive_on),
        .fault        (fault)
    );

    commutator u_commutator (
        .clk          (clk),
        .rst          (rst),
        .code         (hall_status.code),
        .direction    (direction),
        .drive_on     (drive_on),
        .applied_duty (applied_duty),
        .cmd          (drive_cmd)
    );

    // One generator per half bridge, each takes its own bit of every mask
    for (genvar i = 0; i < $bits(phase_mask_t); i++) begin : gen_phase
        phase_pwm u_phase_pwm (
            .clk       (clk),
            .rst       (rst),
            .duty      (drive_cmd.duty),
            .pwm_sel   (drive_cmd.pwm_mask[i]),
            .low_sel   (drive_cmd.low_mask[i]),
            .float_sel (drive_cmd.float_mask[i]),
            .gate_h    (phase_h[i]),
            .gate_l    (phase_l[i])
        );
    end

endmodule

// File: tests/tb_bldc_driver.sv
/*
 * BLDC driver testbench: directed tests of reset, startup and run,
 * dead time, stop conditions, hall fault and sensor disconnect
 */
`timescale 1ns/1ps
`include "bldc_settings.svh"

module tb_bldc_driver import bldc_pkg::*; ();

    localparam int period = 1 << `BLDC_DUTY_WIDTH;
    localparam int dead   = `BLDC_DEAD_TIME;
    localparam int ramp_cycles = `BLDC_RAMP_STEPS * `BLDC_RAMP_TICK_CYCLES;

    // Conditions that the wait loop can poll
    localparam int cond_idle        = 0;
    localparam int cond_driving     = 1;
    localparam int cond_fault       = 2;
    localparam int cond_fault_clear = 3;
    localparam int cond_connected   = 4;
    localparam int cond_unplugged   = 5;

    // Six-step table for forward rotation, indexed by hall code.
    // Entries give the phase number (a=0, b=1, c=2), -1 for invalid codes
    localparam int fwd_sw [8]  = '{-1, 0, 1, 0, 2, 2, 1, -1};
    localparam int fwd_low [8] = '{-1, 1, 2, 2, 0, 1, 0, -1};
    localparam hall_t valid_codes [6] = '{3'd1, 3'd3, 3'd2, 3'd6, 3'd4, 3'd5};

    logic        clk;
    logic        rst;
    logic        en;
    hall_t       hall;
    duty_t       duty;
    logic        direction;
    phase_mask_t phase_h;
    phase_mask_t phase_l;
    logic        connected;
    logic        fault;

    integer seed = 69;
    int     checks = 0;
    int     errors = 0;
    int     dead_errors = 0;
    // Per phase bookkeeping of the dead-time monitor
    int     off_run [3];
    int     last_side [3];

    bldc_driver dut0 (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .hall      (hall),
        .duty      (duty),
        .direction (direction),
        .phase_h   (phase_h),
        .phase_l   (phase_l),
        .connected (connected),
        .fault     (fault)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================

    task automatic compare_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic cond_met(input int sel);
        case (sel)
            cond_idle:        return (phase_h == '0) && (phase_l == '0);
            cond_driving:     return (phase_h | phase_l) != '0;
            cond_fault:       return fault;
            cond_fault_clear: return !fault;
            cond_connected:   return connected;
            cond_unplugged:   return !connected;
            default:          return 1'b0;
        endcase
    endfunction

    // Polls once per cycle at the falling edge, gives up after limit cycles
    task automatic wait_until(input int sel, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!cond_met(sel) && n < limit) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (!cond_met(sel)) begin
            errors++;
            $display("Timeout after %0d cycles waiting for %s", limit, what);
        end
    endtask

    // All gates off and no fault for a number of cycles
    task automatic expect_idle(input int cycles, input logic exp_conn);
        repeat (cycles) begin
            @(negedge clk);
            compare_value("phase_h", int'(phase_h), 0);
            compare_value("phase_l", int'(phase_l), 0);
            compare_value("fault", int'(fault), 0);
            compare_value("connected", int'(connected), int'(exp_conn));
        end
    endtask

    // Reverse rotation swaps the switching and the low phase
    function automatic void predict_roles(input hall_t code, input logic dir,
                                          output int sw, output int lo);
        sw = dir ? fwd_low[code] : fwd_sw[code];
        lo = dir ? fwd_sw[code] : fwd_low[code];
    endfunction

    function automatic hall_t pick_code();
        int idx;
        idx = {$random(seed)} % 6;
        return valid_codes[idx];
    endfunction

    task automatic apply_inputs(input hall_t code, input logic dir, input duty_t d);
        @(posedge clk);
        hall      <= code;
        direction <= dir;
        duty      <= d;
        en        <= 1'b1;
    endtask

    // The startup ramp has a fixed length, run gets extra room to settle
    task automatic settle_ramp();
        repeat (ramp_cycles + 1100) @(negedge clk);
    endtask

    // Counts gate cycles over one full PWM period and checks the roles
    task automatic measure_period(input hall_t code, input logic dir, input duty_t d);
        int h_cnt [3];
        int l_cnt [3];
        int sw;
        int lo;
        int fl;
        int l_exp;
        predict_roles(code, dir, sw, lo);
        fl = 3 - sw - lo;
        l_exp = (int'(d) + dead < period) ? period - int'(d) - dead : 0;
        for (int p = 0; p < 3; p++) begin
            h_cnt[p] = 0;
            l_cnt[p] = 0;
        end
        repeat (period) begin
            @(negedge clk);
            for (int p = 0; p < 3; p++) begin
                h_cnt[p] += int'(phase_h[p]);
                l_cnt[p] += int'(phase_l[p]);
            end
        end
        compare_value($sformatf("phase_h[%0d] on cycles", sw), h_cnt[sw], int'(d) - dead);
        compare_value($sformatf("phase_l[%0d] on cycles", sw), l_cnt[sw], l_exp);
        compare_value($sformatf("phase_h[%0d] on cycles", lo), h_cnt[lo], 0);
        compare_value($sformatf("phase_l[%0d] on cycles", lo), l_cnt[lo], period);
        compare_value($sformatf("phase_h[%0d] on cycles", fl), h_cnt[fl], 0);
        compare_value($sformatf("phase_l[%0d] on cycles", fl), l_cnt[fl], 0);
    endtask

    // ============================================================
    // Dead-time monitor, active through every test
    // ============================================================

    always @(negedge clk) begin
        if (rst) begin
            for (int p = 0; p < 3; p++) begin
                off_run[p]   = 0;
                last_side[p] = 0;
            end
        end else begin
            for (int p = 0; p < 3; p++) begin
                if (phase_h[p] && phase_l[p]) begin
                    dead_errors++;
                    $display("Shoot-through on phase %0d at %0t", p, $time);
                end
                // A handover needs the full dead time with both gates off
                if (phase_h[p] && last_side[p] == 2 && off_run[p] < dead) begin
                    dead_errors++;
                    $display("Only %0d off cycles before high side of phase %0d at %0t",
                             off_run[p], p, $time);
                end
                if (phase_l[p] && last_side[p] == 1 && off_run[p] < dead) begin
                    dead_errors++;
                    $display("Only %0d off cycles before low side of phase %0d at %0t",
                             off_run[p], p, $time);
                end
                if (phase_h[p]) begin
                    last_side[p] = 1;
                    off_run[p]   = 0;
                end else if (phase_l[p]) begin
                    last_side[p] = 2;
                    off_run[p]   = 0;
                end else begin
                    off_run[p]++;
                end
            end
        end
    end

    // ============================================================
    // Directed tests
    // ============================================================

    // Enable low keeps the bridges off even with a valid code and duty
    task automatic check_reset_state();
        expect_idle(1, 1'b1);
        @(posedge clk);
        duty <= duty_t'(600);
        expect_idle(200, 1'b1);
    endtask

    task automatic run_commutation();
        hall_t code;
        logic  dir;
        duty_t d;
        code = pick_code();
        dir = 1'b0;
        d = duty_t'(600);
        apply_inputs(code, dir, d);
        wait_until(cond_driving, 200, "drive to start");
        settle_ramp();
        measure_period(code, dir, d);
        repeat (4) begin
            code = pick_code();
            // Alternate the rotation so both directions are measured
            dir = ~dir;
            d = duty_t'(60 + {$random(seed)} % 900);
            apply_inputs(code, dir, d);
            repeat (32) @(negedge clk);
            measure_period(code, dir, d);
        end
    endtask

    task automatic stop_below_min();
        @(posedge clk);
        duty <= duty_t'(`BLDC_MIN_DUTY);
        wait_until(cond_idle, 20, "gates off at minimum duty");
        expect_idle(100, 1'b1);
        @(posedge clk);
        duty <= duty_t'(10);
        expect_idle(100, 1'b1);
        // Restart, then drop the enable
        @(posedge clk);
        duty <= duty_t'(600);
        wait_until(cond_driving, 50, "drive to restart");
        @(posedge clk);
        en <= 1'b0;
        wait_until(cond_idle, 20, "gates off after enable drop");
        expect_idle(100, 1'b1);
    endtask

    task automatic hall_fault();
        hall_t code;
        code = pick_code();
        apply_inputs(code, 1'b0, duty_t'(600));
        wait_until(cond_driving, 50, "drive to start before hall fault");
        @(posedge clk);
        hall <= 3'd0;
        wait_until(cond_fault, 400, "fault on all-low hall code");
        compare_value("phase_h", int'(phase_h), 0);
        compare_value("phase_l", int'(phase_l), 0);
        // Unplugging the sensor is what clears the fault
        @(posedge clk);
        hall <= 3'd7;
        duty <= '0;
        wait_until(cond_fault_clear, 400, "fault to clear on all-high code");
        compare_value("connected", int'(connected), 0);
        compare_value("phase_h", int'(phase_h), 0);
        compare_value("phase_l", int'(phase_l), 0);
        @(posedge clk);
        hall <= code;
        wait_until(cond_connected, 400, "reconnection after fault");
        expect_idle(100, 1'b1);
        @(posedge clk);
        duty <= duty_t'(700);
        wait_until(cond_driving, 50, "drive after reconnection");
    endtask

    task automatic disconnect_while_running();
        hall_t code;
        logic  dir;
        int    r;
        code = pick_code();
        r = $random(seed);
        dir = r[0];
        apply_inputs(code, dir, duty_t'(500));
        wait_until(cond_driving, 50, "drive before disconnect");
        settle_ramp();
        measure_period(code, dir, duty_t'(500));
        @(posedge clk);
        hall <= 3'd7;
        wait_until(cond_unplugged, 400, "connected to drop");
        compare_value("fault", int'(fault), 0);
        compare_value("phase_h", int'(phase_h), 0);
        compare_value("phase_l", int'(phase_l), 0);
        expect_idle(100, 1'b0);
        @(posedge clk);
        hall <= code;
        wait_until(cond_connected, 400, "reconnection while enabled");
        wait_until(cond_driving, 50, "drive to resume");
        settle_ramp();
        measure_period(code, dir, duty_t'(500));
    endtask

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        rst       <= 1'b1;
        en        <= 1'b0;
        hall      <= 3'd1;
        duty      <= '0;
        direction <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        run_commutation();
        stop_below_min();
        hall_fault();
        disconnect_while_running();
        $display("Checks: %0d, value errors: %0d, dead-time errors: %0d",
                 checks, errors, dead_errors);
        if (errors == 0 && dead_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: bldc_driver.f
+incdir+logic
logic/bldc_pkg.sv
logic/hall_monitor.sv
logic/ramp_timer.sv
logic/motor_fsm.sv
logic/commutator.sv
logic/phase_pwm.sv
logic/bldc_driver.sv
tests/tb_bldc_driver.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the BLDC driver testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f bldc_driver.f --top-module tb_bldc_driver \
        -o tb_bldc_driver \
    && ./obj_dir/tb_bldc_driver 2>&1 | tee "$log" \
    || { echo "Simulation build or run did not complete"; exit 1; }

grep -q "Test failed" "$log" && { echo "Failures reported in $log"; exit 1; }
echo "No failures reported in $log"
